// ==== bench/axi_mem_testdata.txt ====
// kind addr len resp, one test per line, all hex, len is beats minus one
// kinds 1 burst, 2 stalled burst, 3 strobe, 4 mtime, 5 console, 6 error, 0 ends
1 80000000 0  0
1 80000100 7  0
4 a0000048 0  0
2 80000200 f  0
3 80000040 3  0
5 a00003f8 5  0
6 10000000 3  2
6 a0000050 1  2
2 80003f00 1f 0
3 80001000 7  0
1 80003ff0 3  0
4 a0000048 0  0
0 00000000 0  0

// ==== sim.f ====
+incdir+logic
+incdir+bench
logic/axi_mem_pkg.sv
logic/mem_req_if.sv
logic/burst_sequencer.sv
logic/req_fifo.sv
logic/mem_bank.sv
logic/axi_mem_top.sv
bench/axi_mem_tb.sv

// ==== Makefile ====
TOP := axi_mem_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== bench/axi_mem_tb_tasks.svh ====
`ifndef AXI_MEM_TB_TASKS_SVH
`define AXI_MEM_TB_TASKS_SVH

// fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
   logic fb;
   fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
   lfsr_state = {lfsr_state[30:0], fb};
   return fb;
endfunction

function automatic logic [31:0] random_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
   return v;
endfunction

task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
   if (got !== exp) begin
      $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
   end
endtask

// ============================================================================
// AXI master side, drive on posedge and sample on negedge
// ============================================================================
task automatic write_burst(input addr_t addr, input len_t len, input logic stall);
   @(posedge clk);
   awaddr  <= addr;
   awlen   <= len;
   awvalid <= 1'b1;
   do @(negedge clk); while (!awready);
   @(posedge clk);
   awvalid <= 1'b0;
   for (int i = 0; i <= int'(len); i++) begin
      wdata  <= wr_data[i];
      wstrb  <= wr_strb[i];
      wlast  <= (i == int'(len));
      wvalid <= 1'b1;
      do @(negedge clk); while (!wready);
      @(posedge clk);
   end
   wvalid <= 1'b0;
   wlast  <= 1'b0;
   forever begin
      bready <= stall ? lfsr_bit() : 1'b1;   // random gaps on B
      @(negedge clk);
      if (bvalid && bready) break;
      @(posedge clk);
   end
   last_bresp = bresp;
   @(posedge clk);
   bready <= 1'b0;
   @(negedge clk);
   check_value("no extra B response", 64'(bvalid), 64'd0);
endtask

task automatic read_burst(input addr_t addr, input len_t len, input logic stall);
   rd_data.delete();
   rd_resp.delete();
   rd_last.delete();
   @(posedge clk);
   araddr  <= addr;
   arlen   <= len;
   arvalid <= 1'b1;
   do @(negedge clk); while (!arready);
   @(posedge clk);
   arvalid <= 1'b0;
   for (int i = 0; i <= int'(len); i++) begin
      forever begin
         rready <= stall ? lfsr_bit() : 1'b1;
         @(negedge clk);
         if (rvalid && rready) break;
         @(posedge clk);
      end
      rd_data.push_back(rdata);
      rd_resp.push_back(rresp);
      rd_last.push_back(rlast);
      @(posedge clk);
   end
   rready <= 1'b0;
   @(negedge clk);
   check_value("no extra R beat", 64'(rvalid), 64'd0);
endtask

`endif

// ==== bench/axi_mem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_config.svh"

module axi_mem_tb import axi_mem_pkg::*; ();

   localparam int MAX_TESTS   = 32;
   localparam int KIND_END    = 0;
   localparam int KIND_BURST  = 1;
   localparam int KIND_STALL  = 2;
   localparam int KIND_STROBE = 3;
   localparam int KIND_MTIME  = 4;
   localparam int KIND_CONS   = 5;
   localparam int KIND_ERROR  = 6;

   logic       clk = 1'b0;
   logic       rst;
   addr_t      araddr, awaddr;
   len_t       arlen, awlen;
   logic       arvalid, arready, awvalid, awready;
   data_t      rdata, wdata;
   resp_t      rresp, bresp;
   logic       rlast, rvalid, rready;
   strb_t      wstrb;
   logic       wlast, wvalid, wready, bvalid, bready;
   logic       console_valid;
   logic [7:0] console_char;

   logic [31:0] lfsr_state = 32'd92595;
   logic [7:0]  shadow [addr_t];          // byte model of storage
   data_t       wr_data [$];
   strb_t       wr_strb [$];
   data_t       rd_data [$];
   resp_t       rd_resp [$];
   logic        rd_last [$];
   resp_t       last_bresp;
   logic [7:0]  console_q [$];
   logic [31:0] test_words [4*MAX_TESTS];  // kind, addr, len, resp per test
   int          watchdog_cycles = 0;

   `include "axi_mem_tb_tasks.svh"

   axi_mem_top axi_mem_top_i (.*);

   always #2 clk = !clk;

   // console characters as they leave the bank
   always @(negedge clk) begin
      if (!rst && console_valid) console_q.push_back(console_char);
   end

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout: the test did not finish within %0d cycles", watchdog_cycles);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
   end

   // ========================================================================
   // stimulus model
   // ========================================================================
   function automatic data_t shadow_word(input addr_t a);
      return {shadow[a + 32'd3], shadow[a + 32'd2], shadow[a + 32'd1], shadow[a]};
   endfunction

   // random words, full or random strobes, shadow follows the strobes
   task automatic fill_write(input addr_t addr, input len_t len, input logic partial);
      addr_t a;
      wr_data.delete();
      wr_strb.delete();
      for (int i = 0; i <= int'(len); i++) begin
         a = addr + 32'(4 * i);
         wr_data.push_back(random_bits(32));
         wr_strb.push_back(partial ? strb_t'(random_bits(4)) : 4'hf);
         for (int b = 0; b < 4; b++) begin
            if (wr_strb[i][b]) shadow[a + 32'(b)] = wr_data[i][8*b +: 8];
         end
      end
   endtask

   task automatic compare_read(input addr_t addr, input len_t len, input resp_t exp,
                               input logic check_data);
      for (int i = 0; i <= int'(len); i++) begin
         check_value("rresp", 64'(rd_resp[i]), 64'(exp));
         check_value("rlast", 64'(rd_last[i]), 64'(i == int'(len)));
         if (check_data) begin
            check_value("rdata", 64'(rd_data[i]), 64'(shadow_word(addr + 32'(4 * i))));
         end
      end
   endtask

   task automatic burst_test(input addr_t addr, input len_t len, input resp_t exp,
                             input logic stall);
      fill_write(addr, len, 1'b0);
      write_burst(addr, len, stall);
      check_value("bresp", 64'(last_bresp), 64'(exp));
      read_burst(addr, len, stall);
      compare_read(addr, len, exp, 1'b1);
   endtask

   // full words first so every byte is known, then a masked pass
   task automatic strobe_test(input addr_t addr, input len_t len, input resp_t exp);
      fill_write(addr, len, 1'b0);
      write_burst(addr, len, 1'b0);
      check_value("bresp", 64'(last_bresp), 64'(exp));
      fill_write(addr, len, 1'b1);
      write_burst(addr, len, 1'b0);
      check_value("bresp", 64'(last_bresp), 64'(exp));
      read_burst(addr, len, 1'b0);
      compare_read(addr, len, exp, 1'b1);
   endtask

   task automatic mtime_test(input addr_t addr, input resp_t exp);
      data_t first;
      read_burst(addr, 8'd0, 1'b0);
      check_value("mtime rresp", 64'(rd_resp[0]), 64'(exp));
      first = rd_data[0];
      repeat (16) @(posedge clk);
      read_burst(addr, 8'd0, 1'b0);
      check_value("mtime increases", 64'(rd_data[0] > first), 64'd1);
      read_burst(`MTIME_HI_ADDR, 8'd0, 1'b0);
      check_value("mtime high word", 64'(rd_data[0]), 64'd0);
   endtask

   // one single-beat write per character
   task automatic console_test(input addr_t addr, input len_t len, input resp_t exp);
      logic [7:0] sent [$];
      console_q.delete();
      for (int i = 0; i <= int'(len); i++) begin
         sent.push_back(8'(random_bits(8)));
         wr_data.delete();
         wr_strb.delete();
         wr_data.push_back({24'd0, sent[i]});
         wr_strb.push_back(4'h1);
         write_burst(addr, 8'd0, 1'b0);
         check_value("console bresp", 64'(last_bresp), 64'(exp));
      end
      check_value("console char count", 64'(console_q.size()), 64'(sent.size()));
      foreach (sent[i]) check_value("console char", 64'(console_q[i]), 64'(sent[i]));
   endtask

   task automatic error_test(input addr_t addr, input len_t len, input resp_t exp);
      fill_write(addr, len, 1'b0);
      write_burst(addr, len, 1'b0);
      check_value("error bresp", 64'(last_bresp), 64'(exp));
      read_burst(addr, len, 1'b0);
      compare_read(addr, len, exp, 1'b0);
   endtask

   // ========================================================================
   // test sequence
   // ========================================================================
   initial begin
      int    n_tests;
      int    total_beats;
      int    kind;
      addr_t addr;
      len_t  len;
      resp_t exp;
      rst     = 1'b1;
      araddr  = '0;
      arlen   = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      awaddr  = '0;
      awlen   = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wlast   = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      foreach (test_words[i]) test_words[i] = '0;
      $readmemh("bench/axi_mem_testdata.txt", test_words);
      n_tests     = 0;
      total_beats = 0;
      while (n_tests < MAX_TESTS && test_words[4*n_tests] != KIND_END) begin
         total_beats += int'(test_words[4*n_tests + 2]) + 1;
         n_tests++;
      end
      watchdog_cycles = 200 * (total_beats + 1);

      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      for (int t = 0; t < n_tests; t++) begin
         kind = int'(test_words[4*t]);
         addr = test_words[4*t + 1];
         len  = len_t'(test_words[4*t + 2]);
         exp  = resp_t'(test_words[4*t + 3]);
         case (kind)
            KIND_BURST:  burst_test(addr, len, exp, 1'b0);
            KIND_STALL:  burst_test(addr, len, exp, 1'b1);
            KIND_STROBE: strobe_test(addr, len, exp);
            KIND_MTIME:  mtime_test(addr, exp);
            KIND_CONS:   console_test(addr, len, exp);
            KIND_ERROR:  error_test(addr, len, exp);
            default: begin
               $display("Test %0d has an unknown kind %0d in the data file", t, kind);
               $display("Simulation finished: FAIL");
               $fatal(1, "bad test data");
            end
         endcase
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/axi_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_mem_top import axi_mem_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst,
   // read address and data
   input  wire addr_t araddr,
   input  wire len_t  arlen,
   input  wire logic  arvalid,
   output logic       arready,
   output data_t      rdata,
   output resp_t      rresp,
   output logic       rlast,
   output logic       rvalid,
   input  wire logic  rready,
   // write address, data and response
   input  wire addr_t awaddr,
   input  wire len_t  awlen,
   input  wire logic  awvalid,
   output logic       awready,
   input  wire data_t wdata,
   input  wire strb_t wstrb,
   input  wire logic  wlast,
   input  wire logic  wvalid,
   output logic       wready,
   output resp_t      bresp,
   output logic       bvalid,
   input  wire logic  bready,
   // console
   output logic       console_valid,
   output logic [7:0] console_char
);

   mem_req_if seq_req ();    // sequencer to queue
   mem_req_if bank_req ();   // queue to bank

   burst_sequencer burst_sequencer_i (
      .clk     (clk),
      .rst     (rst),
      .araddr  (araddr),
      .arlen   (arlen),
      .arvalid (arvalid),
      .arready (arready),
      .awaddr  (awaddr),
      .awlen   (awlen),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wlast   (wlast),
      .wvalid  (wvalid),
      .wready  (wready),
      .req     (seq_req.producer)
   );

   req_fifo req_fifo_i (
      .clk  (clk),
      .rst  (rst),
      .push (seq_req.consumer),
      .pop  (bank_req.producer)
   );

   mem_bank mem_bank_i (
      .clk           (clk),
      .rst           (rst),
      .req           (bank_req.consumer),
      .rdata         (rdata),
      .rresp         (rresp),
      .rlast         (rlast),
      .rvalid        (rvalid),
      .rready        (rready),
      .bresp         (bresp),
      .bvalid        (bvalid),
      .bready        (bready),
      .console_valid (console_valid),
      .console_char  (console_char)
   );

endmodule

`default_nettype wire

// ==== logic/mem_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_config.svh"

module mem_bank import axi_mem_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst,
   mem_req_if.consumer req,
   // R
   output data_t      rdata,
   output resp_t      rresp,
   output logic       rlast,
   output logic       rvalid,
   input  wire logic  rready,
   // B
   output resp_t      bresp,
   output logic       bvalid,
   input  wire logic  bready,
   // console
   output logic       console_valid,
   output logic [7:0] console_char
);

   localparam int MEM_BYTES = `MEM_WORDS * 4;
   localparam int IDX_W     = $clog2(MEM_BYTES);

   logic [7:0]       mem [MEM_BYTES];   // little endian bytes from MEM_BASE
   logic [63:0]      mtime;
   addr_t            mem_off;
   logic [IDX_W-1:0] byte_idx;
   logic             hit_mem, hit_mtime_lo, hit_mtime_hi, hit_console, hit_any;
   logic             rd_fire, wr_fire;
   logic             wr_err;            // sticky over the write burst
   logic             burst_err;
   data_t            rd_word;

   // ========================================================================
   // address decode
   // ========================================================================
   assign mem_off      = req.addr - addr_t'(`MEM_BASE);
   assign byte_idx     = {mem_off[IDX_W-1:2], 2'b00};
   assign hit_mem      = (mem_off < addr_t'(MEM_BYTES));   // below base wraps high
   assign hit_mtime_lo = (req.addr == addr_t'(`MTIME_LO_ADDR));
   assign hit_mtime_hi = (req.addr == addr_t'(`MTIME_HI_ADDR));
   assign hit_console  = (req.addr == addr_t'(`CONSOLE_ADDR));
   assign hit_any      = hit_mem || hit_mtime_lo || hit_mtime_hi || hit_console;

   // stall the queue while a response waits on the master
   assign req.ready = !rvalid && !bvalid;
   assign rd_fire   = req.valid && req.ready && (req.op == REQ_READ);
   assign wr_fire   = req.valid && req.ready && (req.op == REQ_WRITE);
   assign burst_err = wr_err || !hit_any;

   always_comb begin
      if (hit_mem) begin
         rd_word = {mem[byte_idx + IDX_W'(3)], mem[byte_idx + IDX_W'(2)],
                    mem[byte_idx + IDX_W'(1)], mem[byte_idx]};
      end else if (hit_mtime_lo) begin
         rd_word = mtime[31:0];
      end else if (hit_mtime_hi) begin
         rd_word = mtime[63:32];
      end else begin
         rd_word = '0;   // console and holes read zero
      end
   end

   // free running timer
   always_ff @(posedge clk) begin
      if (rst) mtime <= '0;
      else     mtime <= mtime + 64'd1;
   end

   // byte lane writes, mtime writes dropped
   always_ff @(posedge clk) begin
      if (wr_fire && hit_mem) begin
         for (int b = 0; b < 4; b++) begin
            if (req.strb[b]) mem[byte_idx + IDX_W'(b)] <= req.wdata[8*b +: 8];
         end
      end
   end

   // ========================================================================
   // R and B channels
   // ========================================================================
   always_ff @(posedge clk) begin
      if (rd_fire) begin
         rdata <= rd_word;
         rresp <= hit_any ? RESP_OKAY : RESP_SLVERR;
         rlast <= req.last;
      end
      if (wr_fire && req.last) bresp <= burst_err ? RESP_SLVERR : RESP_OKAY;
      console_char <= req.wdata[7:0];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rvalid        <= 1'b0;
         bvalid        <= 1'b0;
         wr_err        <= 1'b0;
         console_valid <= 1'b0;
      end else begin
         if (rd_fire)                rvalid <= 1'b1;
         else if (rvalid && rready)  rvalid <= 1'b0;
         if (wr_fire && req.last)    bvalid <= 1'b1;
         else if (bvalid && bready)  bvalid <= 1'b0;
         if (wr_fire) wr_err <= req.last ? 1'b0 : burst_err;   // clear per burst
         console_valid <= wr_fire && hit_console && req.strb[0];
      end
   end

endmodule

`default_nettype wire

// ==== logic/req_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "axi_mem_config.svh"

module req_fifo import axi_mem_pkg::*; #(
   parameter int DEPTH = `REQ_FIFO_DEPTH
) (
   input  wire logic clk,
   input  wire logic rst,
   mem_req_if.consumer push,
   mem_req_if.producer pop
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // entry storage, one array per field
   req_op_e op_q   [DEPTH];
   addr_t   addr_q [DEPTH];
   data_t   data_q [DEPTH];
   strb_t   strb_q [DEPTH];
   logic    last_q [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push_fire;
   logic             pop_fire;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(DEPTH - 1)) return '0;   // wrap for any depth
      return p + PTR_W'(1);
   endfunction

   assign push.ready = (count != CNT_W'(DEPTH));   // low when full
   assign pop.valid  = (count != '0);
   assign push_fire  = push.valid && push.ready;
   assign pop_fire   = pop.valid && pop.ready;

   assign pop.op    = op_q[rd_ptr];
   assign pop.addr  = addr_q[rd_ptr];
   assign pop.wdata = data_q[rd_ptr];
   assign pop.strb  = strb_q[rd_ptr];
   assign pop.last  = last_q[rd_ptr];

   always_ff @(posedge clk) begin
      if (push_fire) begin
         op_q[wr_ptr]   <= push.op;
         addr_q[wr_ptr] <= push.addr;
         data_q[wr_ptr] <= push.wdata;
         strb_q[wr_ptr] <= push.strb;
         last_q[wr_ptr] <= push.last;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_fire) wr_ptr <= next_ptr(wr_ptr);
         if (pop_fire)  rd_ptr <= next_ptr(rd_ptr);
         if (push_fire && !pop_fire) begin
            count <= count + CNT_W'(1);
         end else if (pop_fire && !push_fire) begin
            count <= count - CNT_W'(1);
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/burst_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module burst_sequencer import axi_mem_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst,
   // AR
   input  wire addr_t araddr,
   input  wire len_t  arlen,
   input  wire logic  arvalid,
   output logic       arready,
   // AW
   input  wire addr_t awaddr,
   input  wire len_t  awlen,
   input  wire logic  awvalid,
   output logic       awready,
   // W
   input  wire data_t wdata,
   input  wire strb_t wstrb,
   input  wire logic  wlast,
   input  wire logic  wvalid,
   output logic       wready,
   mem_req_if.producer req
);

   seq_state_e state;
   addr_t      beat_addr;
   len_t       beat_len;
   len_t       beat_cnt;
   logic       last_beat;
   logic       push;

   assign last_beat = (beat_cnt == beat_len);
   assign push      = req.valid && req.ready;

   // write wins when both address channels are offered
   assign awready = (state == SEQ_IDLE);
   assign arready = (state == SEQ_IDLE) && !awvalid;

   // ========================================================================
   // burst FSM
   // ========================================================================
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= SEQ_IDLE;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (awvalid) begin
                  state <= SEQ_WRITE;
               end else if (arvalid) begin
                  state <= SEQ_READ;
               end
            end
            SEQ_READ, SEQ_WRITE: begin
               if (push && req.last) state <= SEQ_IDLE;
            end
            default: state <= SEQ_IDLE;
         endcase
      end
   end

   // address and beat counter, loaded on the address handshake
   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         beat_addr <= awaddr;
         beat_len  <= awlen;
         beat_cnt  <= '0;
      end else if (arvalid && arready) begin
         beat_addr <= araddr;
         beat_len  <= arlen;
         beat_cnt  <= '0;
      end else if (push) begin
         beat_addr <= beat_addr + addr_t'(4);   // INCR only
         beat_cnt  <= beat_cnt + len_t'(1);
      end
   end

   // ========================================================================
   // request generation
   // ========================================================================
   always_comb begin
      req.valid = 1'b0;
      req.op    = REQ_READ;
      req.addr  = beat_addr;
      req.wdata = '0;
      req.strb  = '0;
      req.last  = last_beat;
      wready    = 1'b0;
      case (state)
         SEQ_READ: begin
            req.valid = 1'b1;   // beats generated here, no data
         end
         SEQ_WRITE: begin
            req.valid = wvalid;
            req.op    = REQ_WRITE;
            req.wdata = wdata;
            req.strb  = wstrb;
            wready    = req.ready;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/mem_req_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one word-sized memory request per transfer
interface mem_req_if import axi_mem_pkg::*; ();

   logic    valid;
   logic    ready;
   req_op_e op;
   addr_t   addr;    // byte address of this beat
   data_t   wdata;
   strb_t   strb;
   logic    last;    // closes the burst

   modport producer (
      output valid, op, addr, wdata, strb, last,
      input  ready
   );

   modport consumer (
      input  valid, op, addr, wdata, strb, last,
      output ready
   );

endinterface

`default_nettype wire

// ==== logic/axi_mem_pkg.sv ====
`default_nettype none

package axi_mem_pkg;

   // ========================================================================
   // bus field widths
   // ========================================================================
   typedef logic [31:0] addr_t;   // byte address
   typedef logic [31:0] data_t;   // one beat
   typedef logic [3:0]  strb_t;   // byte enables
   typedef logic [7:0]  len_t;    // beats minus one
   typedef logic [1:0]  resp_t;

   localparam resp_t RESP_OKAY   = 2'd0;
   localparam resp_t RESP_SLVERR = 2'd2;

   // ========================================================================
   // request and FSM encodings
   // ========================================================================
   typedef enum logic {
      REQ_READ,
      REQ_WRITE
   } req_op_e;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_READ,
      SEQ_WRITE
   } seq_state_e;

endpackage

`default_nettype wire

// ==== logic/axi_mem_config.svh ====
`ifndef AXI_MEM_CONFIG_SVH
`define AXI_MEM_CONFIG_SVH

// storage window, word count of the byte array
`define MEM_BASE        32'h8000_0000
`define MEM_WORDS       4096

// clint timer halves
`define MTIME_LO_ADDR   32'ha000_0048
`define MTIME_HI_ADDR   32'ha000_004c

// byte writes here go out as characters
`define CONSOLE_ADDR    32'ha000_03f8

// entries between sequencer and bank
`define REQ_FIFO_DEPTH  4

`endif
